// File: ahbl_port_monitor.f
+incdir+.
ahbl_mon_pkg.sv
ahbl_rule_checker.sv
violation_fifo.sv
apb_violation_regs.sv
ahbl_port_monitor.sv
tb_ahbl_port_monitor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 \
	--top-module tb_ahbl_port_monitor \
	-f ahbl_port_monitor.f \
	-o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "sim passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb_bus_tasks.svh
// ==================================================
// testbench tasks for AHB port cycles, APB accesses
// and value checks. included inside the testbench top.
// ==================================================
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// sets one AHB port's signals without waiting for a clock.
task automatic set_port(input bit port, input logic [31:0] addr, input logic [1:0] trans,
		input logic [2:0] size, input logic wr, input logic [31:0] wdata,
		input logic rdy, input logic resp);
	if (port == I_PORT) begin
		i_haddr  = addr;
		i_htrans = trans;
		i_hsize  = size;
		i_hwrite = wr;
		i_hwdata = wdata;
		i_hready = rdy;
		i_hresp  = resp;
	end else begin
		d_haddr  = addr;
		d_htrans = trans;
		d_hsize  = size;
		d_hwrite = wr;
		d_hwdata = wdata;
		d_hready = rdy;
		d_hresp  = resp;
	end
endtask

task automatic idle_port(input bit port);
	set_port(port, 32'h0, HTRANS_IDLE, HSIZE_WORD, 1'b0, 32'h0, 1'b1, 1'b0);
endtask

// waits for the next edge and steps 1 ns past it.
task automatic tick();
	@(posedge clk);
	#1;
endtask

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
	end
endtask

task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = wr;
	paddr   = addr;
	pwdata  = wdata;
	tick();
	penable = 1'b1;
	#1;
	rdata = prdata;
	err   = pslverr;
	if (pready !== 1'b1) begin
		errors++;
		$display("pready was not high in the access phase at offset %h", addr);
	end
	tick();
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

// reads the head record of one port, checks it and pops it.
task automatic expect_record(input string name, input bit port, input logic [2:0] rule,
		input logic [31:0] addr);
	logic [31:0] data;
	logic        err;
	apb_access(1'b0, (port == I_PORT) ? REG_I_RULE : REG_D_RULE, 32'h0, data, err);
	check_val({name, " rule"}, {29'h0, rule}, data);
	apb_access(1'b0, (port == I_PORT) ? REG_I_ADDR : REG_D_ADDR, 32'h0, data, err);
	check_val({name, " addr"}, addr, data);
	apb_access(1'b1, (port == I_PORT) ? REG_I_POP : REG_D_POP, 32'h1, data, err);
endtask

`endif

// File: tb_ahbl_port_monitor.sv
// ==================================================
// testbench for the two-port AHB-Lite monitor. plays
// manager and subordinate, checks records over APB.
// ==================================================
`default_nettype none

module tb_ahbl_port_monitor
	import ahbl_mon_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam bit I_PORT = 1'b0;
	localparam bit D_PORT = 1'b1;
	localparam int TIMEOUT_CYCLES = 400; // tests take about 150 cycles.

	logic        clk;
	logic        rst_n;
	logic [31:0] i_haddr, d_haddr;
	logic [1:0]  i_htrans, d_htrans;
	logic [2:0]  i_hsize, d_hsize;
	logic        i_hwrite, d_hwrite;
	logic [31:0] i_hwdata, d_hwdata;
	logic        i_hready, d_hready;
	logic        i_hresp, d_hresp;
	logic        psel, penable, pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata, prdata;
	logic        pready, pslverr, violation;
	logic [15:0] lfsr;
	int          errors;
	int          checks;
	int          cycles;

	ahbl_port_monitor uut (
		.clk(clk), .i_rst_n(rst_n),
		.i_i_haddr(i_haddr), .i_i_htrans(i_htrans), .i_i_hsize(i_hsize),
		.i_i_hwrite(i_hwrite), .i_i_hwdata(i_hwdata),
		.i_i_hready(i_hready), .i_i_hresp(i_hresp),
		.i_d_haddr(d_haddr), .i_d_htrans(d_htrans), .i_d_hsize(d_hsize),
		.i_d_hwrite(d_hwrite), .i_d_hwdata(d_hwdata),
		.i_d_hready(d_hready), .i_d_hresp(d_hresp),
		.i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
		.i_paddr(paddr), .i_pwdata(pwdata),
		.o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
		.o_violation(violation)
	);

	`include "tb_bus_tasks.svh"

	// galois lfsr stepped once per bit taken.
	function automatic logic [31:0] lfsr_take(input int nbits);
		logic [31:0] val;
		val = '0;
		for (int k = 0; k < nbits; k++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return val;
	endfunction

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==================================================
	// timeout.
	// ==================================================
	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
				$display("sim failed");
				$finish;
			end
		end
	end

	task automatic clean_tick();
		tick();
		check_val("clean violation", 32'h0, {31'h0, violation});
	endtask

	task automatic clean_traffic();
		logic [31:0] data;
		logic        err;
		int          waits;
		for (int n = 0; n < 6; n++) begin
			set_port(I_PORT, lfsr_take(30) << 2, HTRANS_NONSEQ, HSIZE_WORD, 1'b1, 32'h0,
				1'b1, 1'b0);
			set_port(D_PORT, lfsr_take(30) << 2, HTRANS_NONSEQ, HSIZE_WORD, 1'b1, 32'h0,
				1'b1, 1'b0);
			clean_tick();
			waits = int'(lfsr_take(1)) + 1;
			data  = lfsr_take(32);
			for (int w = 0; w <= waits; w++) begin
				set_port(I_PORT, 32'h0, HTRANS_IDLE, HSIZE_WORD, 1'b0, data, w == waits, 1'b0);
				set_port(D_PORT, 32'h0, HTRANS_IDLE, HSIZE_WORD, 1'b0, ~data, w == waits, 1'b0);
				clean_tick();
			end
		end
		idle_port(I_PORT);
		idle_port(D_PORT);
		apb_access(1'b0, REG_STATUS, 32'h0, data, err);
		check_val("clean status", 32'h0, data);
		apb_access(1'b0, REG_DROPS, 32'h0, data, err);
		check_val("clean drops", 32'h0, data);
	endtask

	task automatic misaligned_record();
		logic [31:0] data;
		logic        err;
		set_port(I_PORT, 32'h0000_1001, HTRANS_NONSEQ, 3'd1, 1'b0, 32'h0, 1'b1, 1'b0);
		tick();
		idle_port(I_PORT);
		tick();
		check_val("misaligned violation", 32'h1, {31'h0, violation});
		expect_record("misaligned", I_PORT, RULE_MISALIGNED, 32'h0000_1001);
		apb_access(1'b0, REG_STATUS, 32'h0, data, err);
		check_val("misaligned status", 32'h0, data);
	endtask

	task automatic d_port_order();
		set_port(D_PORT, 32'h0000_2000, HTRANS_SEQ, HSIZE_WORD, 1'b0, 32'h0, 1'b1, 1'b0);
		tick();
		set_port(D_PORT, 32'h0000_2008, HTRANS_NONSEQ, 3'd3, 1'b0, 32'h0, 1'b1, 1'b0);
		tick();
		idle_port(D_PORT);
		tick();
		expect_record("seq after idle", D_PORT, RULE_SEQ_AFTER_IDLE, 32'h0000_2000);
		expect_record("bad size", D_PORT, RULE_BAD_SIZE, 32'h0000_2008);
	endtask

	task automatic wait_state_rules();
		logic [31:0] data;
		logic        err;
		set_port(I_PORT, 32'h0000_3000, HTRANS_NONSEQ, HSIZE_WORD, 1'b0, 32'h0, 1'b1, 1'b0);
		tick();
		// the second transfer stalls and its address moves in the 2nd wait cycle.
		for (int w = 0; w < MAX_BUS_STALL + 2; w++) begin
			set_port(I_PORT, (w == 0) ? 32'h0000_3004 : 32'h0000_3008, HTRANS_NONSEQ,
				HSIZE_WORD, 1'b0, 32'h0, 1'b0, 1'b0);
			tick();
		end
		set_port(I_PORT, 32'h0000_3008, HTRANS_NONSEQ, HSIZE_WORD, 1'b0, 32'h0, 1'b1, 1'b0);
		tick();
		idle_port(I_PORT);
		tick();
		expect_record("addr unstable", I_PORT, RULE_ADDR_UNSTABLE, 32'h0000_3008);
		expect_record("stall limit", I_PORT, RULE_STALL_LIMIT, 32'h0000_3008);
		apb_access(1'b0, REG_STATUS, 32'h0, data, err);
		check_val("stall once status", 32'h0, data);
		set_port(I_PORT, 32'h0000_4000, HTRANS_NONSEQ, HSIZE_WORD, 1'b0, 32'h0, 1'b1, 1'b0);
		tick();
		set_port(I_PORT, 32'h0, HTRANS_IDLE, HSIZE_WORD, 1'b0, 32'h0, 1'b1, 1'b1);
		tick();
		idle_port(I_PORT);
		tick();
		expect_record("err resp", I_PORT, RULE_ERR_RESP, 32'h0);
	endtask

	task automatic fifo_overflow();
		logic [31:0] data;
		logic        err;
		for (int n = 0; n < 6; n++) begin
			set_port(I_PORT, 32'h0000_6001 + 32'(n * 16), HTRANS_NONSEQ, 3'd1, 1'b0, 32'h0,
				1'b1, 1'b0);
			if (n == 0) begin
				set_port(D_PORT, 32'h0000_5000, HTRANS_NONSEQ, 3'd3, 1'b0, 32'h0, 1'b1, 1'b0);
			end else begin
				idle_port(D_PORT);
			end
			tick();
		end
		idle_port(I_PORT);
		tick();
		apb_access(1'b0, REG_DROPS, 32'h0, data, err);
		check_val("overflow drops", 32'h0000_0002, data);
		for (int n = 0; n < 4; n++) begin
			expect_record("overflow", I_PORT, RULE_MISALIGNED, 32'h0000_6001 + 32'(n * 16));
		end
		apb_access(1'b0, REG_STATUS, 32'h0, data, err);
		check_val("overflow status", 32'h2, data);
		expect_record("d independent", D_PORT, RULE_BAD_SIZE, 32'h0000_5000);
	endtask

	task automatic apb_error_responses();
		logic [31:0] data;
		logic        err;
		apb_access(1'b0, 8'h20, 32'h0, data, err);
		check_val("unmapped read pslverr", 32'h1, {31'h0, err});
		apb_access(1'b1, REG_STATUS, 32'h1, data, err);
		check_val("status write pslverr", 32'h1, {31'h0, err});
		apb_access(1'b0, REG_STATUS, 32'h0, data, err);
		check_val("valid read pslverr", 32'h0, {31'h0, err});
	endtask

	initial begin
		errors  = 0;
		checks  = 0;
		lfsr    = 16'd44429;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 8'h0;
		pwdata  = 32'h0;
		idle_port(I_PORT);
		idle_port(D_PORT);
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		tick();
		clean_traffic();
		misaligned_record();
		d_port_order();
		wait_state_rules();
		fifo_overflow();
		apb_error_responses();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: ahbl_port_monitor.sv
// ==================================================
// two-port AHB-Lite monitor top with rule checkers,
// violation FIFOs and the APB register block.
// ==================================================
`default_nettype none

module ahbl_port_monitor
	import ahbl_mon_pkg::*;
(
	input  wire                   clk,
	input  wire                   i_rst_n,

	// instruction port, observed only.
	input  wire  [ADDR_W-1:0]     i_i_haddr,
	input  wire  [1:0]            i_i_htrans,
	input  wire  [2:0]            i_i_hsize,
	input  wire                   i_i_hwrite,
	input  wire  [DATA_W-1:0]     i_i_hwdata,
	input  wire                   i_i_hready,
	input  wire                   i_i_hresp,

	// data port, observed only.
	input  wire  [ADDR_W-1:0]     i_d_haddr,
	input  wire  [1:0]            i_d_htrans,
	input  wire  [2:0]            i_d_hsize,
	input  wire                   i_d_hwrite,
	input  wire  [DATA_W-1:0]     i_d_hwdata,
	input  wire                   i_d_hready,
	input  wire                   i_d_hresp,

	// APB slave.
	input  wire                   i_psel,
	input  wire                   i_penable,
	input  wire                   i_pwrite,
	input  wire  [APB_ADDR_W-1:0] i_paddr,
	input  wire  [DATA_W-1:0]     i_pwdata,
	output logic [DATA_W-1:0]     o_prdata,
	output logic                  o_pready,
	output logic                  o_pslverr,

	output logic                  o_violation
);

	logic              ichk_push, dchk_push;
	logic [RULE_W-1:0] ichk_rule, dchk_rule;
	logic [ADDR_W-1:0] ichk_addr, dchk_addr;

	logic              ififo_ne, dfifo_ne;
	logic [RULE_W-1:0] ififo_rule, dfifo_rule;
	logic [ADDR_W-1:0] ififo_addr, dfifo_addr;
	logic [DROP_W-1:0] ififo_drops, dfifo_drops;
	logic              ipop, dpop;

	assign o_violation = ififo_ne || dfifo_ne;

	// ==================================================
	// instruction port.
	// ==================================================
	ahbl_rule_checker u_i_checker (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_haddr(i_i_haddr), .i_htrans(i_i_htrans), .i_hsize(i_i_hsize),
		.i_hwrite(i_i_hwrite), .i_hwdata(i_i_hwdata),
		.i_hready(i_i_hready), .i_hresp(i_i_hresp),
		.o_push(ichk_push), .o_rule(ichk_rule), .o_addr(ichk_addr)
	);

	violation_fifo u_i_fifo (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_push(ichk_push), .i_rule(ichk_rule), .i_addr(ichk_addr), .i_pop(ipop),
		.o_not_empty(ififo_ne), .o_rule(ififo_rule), .o_addr(ififo_addr),
		.o_drops(ififo_drops)
	);

	// ==================================================
	// data port.
	// ==================================================
	ahbl_rule_checker u_d_checker (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_haddr(i_d_haddr), .i_htrans(i_d_htrans), .i_hsize(i_d_hsize),
		.i_hwrite(i_d_hwrite), .i_hwdata(i_d_hwdata),
		.i_hready(i_d_hready), .i_hresp(i_d_hresp),
		.o_push(dchk_push), .o_rule(dchk_rule), .o_addr(dchk_addr)
	);

	violation_fifo u_d_fifo (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_push(dchk_push), .i_rule(dchk_rule), .i_addr(dchk_addr), .i_pop(dpop),
		.o_not_empty(dfifo_ne), .o_rule(dfifo_rule), .o_addr(dfifo_addr),
		.o_drops(dfifo_drops)
	);

	apb_violation_regs u_regs (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
		.i_paddr(i_paddr), .i_pwdata(i_pwdata),
		.o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
		.i_i_not_empty(ififo_ne), .i_i_rule(ififo_rule), .i_i_addr(ififo_addr),
		.i_i_drops(ififo_drops), .o_i_pop(ipop),
		.i_d_not_empty(dfifo_ne), .i_d_rule(dfifo_rule), .i_d_addr(dfifo_addr),
		.i_d_drops(dfifo_drops), .o_d_pop(dpop)
	);

endmodule

`default_nettype wire

// File: apb_violation_regs.sv
// ==================================================
// APB register block to read status and drop counts
// and to peek and pop both violation FIFOs.
// ==================================================
`default_nettype none

module apb_violation_regs
	import ahbl_mon_pkg::*;
(
	input  wire                   clk,
	input  wire                   i_rst_n,

	// APB slave.
	input  wire                   i_psel,
	input  wire                   i_penable,
	input  wire                   i_pwrite,
	input  wire  [APB_ADDR_W-1:0] i_paddr,
	input  wire  [DATA_W-1:0]     i_pwdata,
	output logic [DATA_W-1:0]     o_prdata,
	output logic                  o_pready,
	output logic                  o_pslverr,

	// i port FIFO.
	input  wire                   i_i_not_empty,
	input  wire  [RULE_W-1:0]     i_i_rule,
	input  wire  [ADDR_W-1:0]     i_i_addr,
	input  wire  [DROP_W-1:0]     i_i_drops,
	output logic                  o_i_pop,

	// d port FIFO.
	input  wire                   i_d_not_empty,
	input  wire  [RULE_W-1:0]     i_d_rule,
	input  wire  [ADDR_W-1:0]     i_d_addr,
	input  wire  [DROP_W-1:0]     i_d_drops,
	output logic                  o_d_pop
);

	logic              access;
	logic              mapped;
	logic              is_pop;     // pop offsets are write-only.
	logic [DATA_W-1:0] rd_data;
	logic              pop_req;

	assign access = i_psel && i_penable;

	// ==================================================
	// address decode.
	// ==================================================
	always_comb begin
		rd_data = '0;
		mapped  = 1'b1;
		is_pop  = 1'b0;
		case (i_paddr)
			REG_STATUS: rd_data = DATA_W'({i_d_not_empty, i_i_not_empty});
			REG_I_RULE: rd_data = DATA_W'(i_i_rule);
			REG_I_ADDR: rd_data = DATA_W'(i_i_addr);
			REG_I_POP:  is_pop  = 1'b1;
			REG_D_RULE: rd_data = DATA_W'(i_d_rule);
			REG_D_ADDR: rd_data = DATA_W'(i_d_addr);
			REG_D_POP:  is_pop  = 1'b1;
			REG_DROPS:  rd_data = DATA_W'({i_d_drops, i_i_drops});
			default:    mapped  = 1'b0;
		endcase
	end

	assign o_pready  = 1'b1; // no wait states.
	assign o_prdata  = (access && !i_pwrite) ? rd_data : '0;
	assign o_pslverr = access && (!mapped || (i_pwrite != is_pop));

	// a pop needs bit 0 of the write data set.
	assign pop_req = access && i_pwrite && i_pwdata[0];
	assign o_i_pop = pop_req && (i_paddr == REG_I_POP);
	assign o_d_pop = pop_req && (i_paddr == REG_D_POP);

endmodule

`default_nettype wire

// File: violation_fifo.sv
// ==================================================
// violation record FIFO for one port, with a
// saturating count of records dropped when full.
// ==================================================
`default_nettype none

module violation_fifo
	import ahbl_mon_pkg::*;
(
	input  wire               clk,
	input  wire               i_rst_n,
	input  wire               i_push,
	input  wire  [RULE_W-1:0] i_rule,
	input  wire  [ADDR_W-1:0] i_addr,
	input  wire               i_pop,
	output logic              o_not_empty,
	output logic [RULE_W-1:0] o_rule,
	output logic [ADDR_W-1:0] o_addr,
	output logic [DROP_W-1:0] o_drops
);

	logic [REC_W-1:0]      mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  full;
	logic                  do_push;
	logic                  do_pop;

	assign full        = (count == FIFO_CNT_W'(FIFO_DEPTH));
	assign o_not_empty = (count != '0);
	assign do_push     = i_push && !full;
	assign do_pop      = i_pop && o_not_empty; // pop while empty is ignored.

	assign {o_rule, o_addr} = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= {i_rule, i_addr};
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			o_drops <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			if (i_push && full && (o_drops != {DROP_W{1'b1}})) begin
				o_drops <= o_drops + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: ahbl_rule_checker.sv
// ==================================================
// passive rule checker for one AHB-Lite manager port.
// emits at most one violation record per cycle.
// ==================================================
`default_nettype none

module ahbl_rule_checker
	import ahbl_mon_pkg::*;
(
	input  wire               clk,
	input  wire               i_rst_n,
	input  wire  [ADDR_W-1:0] i_haddr,
	input  wire  [1:0]        i_htrans,
	input  wire  [2:0]        i_hsize,
	input  wire               i_hwrite,
	input  wire  [DATA_W-1:0] i_hwdata,
	input  wire               i_hready,
	input  wire               i_hresp,
	output logic              o_push,
	output logic [RULE_W-1:0] o_rule,
	output logic [ADDR_W-1:0] o_addr
);

	// history from the previous edge.
	logic [ADDR_W-1:0]  prev_haddr;
	logic [1:0]         prev_htrans;
	logic [2:0]         prev_hsize;
	logic               prev_hwrite;
	logic               prev_hready;
	logic [DATA_W-1:0]  prev_hwdata;

	// transfer currently in its data phase.
	logic               dp_active;
	logic               dp_write;
	logic [ADDR_W-1:0]  dp_addr;

	logic [STALL_W-1:0] stall_cnt;
	logic               err_phase; // first error cycle seen last edge.

	logic               cur_active;
	logic               prev_active;
	logic               accept;
	logic               addr_wait;
	logic               addr_changed;
	logic [ADDR_W-1:0]  size_mask;
	logic               r1, r2, r3, r4, r5, r6, r7;

	assign cur_active  = (i_htrans != HTRANS_IDLE) && (i_htrans != HTRANS_BUSY);
	assign prev_active = (prev_htrans != HTRANS_IDLE) && (prev_htrans != HTRANS_BUSY);
	assign accept      = cur_active && i_hready;

	// a pending transfer was stalled, so its address phase must hold.
	assign addr_wait    = !prev_hready && prev_active && !err_phase;
	assign addr_changed = (i_haddr != prev_haddr) || (i_htrans != prev_htrans) ||
		(i_hsize != prev_hsize) || (i_hwrite != prev_hwrite);

	assign size_mask = ~({ADDR_W{1'b1}} << i_hsize);

	// ==================================================
	// rule flags.
	// ==================================================
	assign r1 = addr_wait && addr_changed;
	assign r2 = (i_htrans == HTRANS_SEQ) && (prev_htrans == HTRANS_IDLE);
	assign r3 = accept && |(i_haddr & size_mask);
	assign r4 = accept && (i_hsize > HSIZE_WORD);
	assign r5 = dp_active && dp_write && !prev_hready && (i_hwdata != prev_hwdata);
	assign r6 = !i_hready && (stall_cnt == STALL_W'(MAX_BUS_STALL));
	assign r7 = (i_hresp && i_hready && !err_phase) ||
		(err_phase && !(i_hresp && i_hready)); // one-phase or broken second phase.

	always_comb begin
		o_push = 1'b1;
		o_addr = i_haddr;
		if (r1) begin
			o_rule = RULE_ADDR_UNSTABLE;
		end else if (r2) begin
			o_rule = RULE_SEQ_AFTER_IDLE;
		end else if (r3) begin
			o_rule = RULE_MISALIGNED;
		end else if (r4) begin
			o_rule = RULE_BAD_SIZE;
		end else if (r5) begin
			o_rule = RULE_WDATA_UNSTABLE;
			o_addr = dp_addr; // report the write being stalled.
		end else if (r6) begin
			o_rule = RULE_STALL_LIMIT;
		end else if (r7) begin
			o_rule = RULE_ERR_RESP;
		end else begin
			o_push = 1'b0;
			o_rule = RULE_NONE;
		end
	end

	// ==================================================
	// history registers.
	// ==================================================
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			prev_htrans <= HTRANS_IDLE;
			prev_hready <= 1'b1;
			dp_active   <= 1'b0;
			stall_cnt   <= '0;
			err_phase   <= 1'b0;
		end else begin
			prev_htrans <= i_htrans;
			prev_hready <= i_hready;
			err_phase   <= i_hresp && !i_hready;
			if (i_hready) begin
				dp_active <= cur_active;
			end
			if (i_hready) begin
				stall_cnt <= '0;
			end else if (stall_cnt != STALL_W'(MAX_BUS_STALL + 1)) begin
				stall_cnt <= stall_cnt + 1'b1; // saturates so rule 6 fires once.
			end
		end
	end

	always_ff @(posedge clk) begin
		prev_haddr  <= i_haddr;
		prev_hsize  <= i_hsize;
		prev_hwrite <= i_hwrite;
		prev_hwdata <= i_hwdata;
		if (accept) begin
			dp_addr  <= i_haddr;
			dp_write <= i_hwrite;
		end
	end

endmodule

`default_nettype wire

// File: ahbl_mon_pkg.sv
// ==================================================
// shared widths, rule codes, limits and APB register
// map for the two-port AHB-Lite monitor.
// ==================================================
`default_nettype none

package ahbl_mon_pkg;

	// bus widths.
	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 32;
	localparam int APB_ADDR_W = 8;

	// ==================================================
	// rule codes, lowest number has priority.
	// ==================================================
	localparam int RULE_W = 3;

	localparam logic [RULE_W-1:0] RULE_NONE           = 3'd0;
	localparam logic [RULE_W-1:0] RULE_ADDR_UNSTABLE  = 3'd1;
	localparam logic [RULE_W-1:0] RULE_SEQ_AFTER_IDLE = 3'd2;
	localparam logic [RULE_W-1:0] RULE_MISALIGNED     = 3'd3;
	localparam logic [RULE_W-1:0] RULE_BAD_SIZE       = 3'd4;
	localparam logic [RULE_W-1:0] RULE_WDATA_UNSTABLE = 3'd5;
	localparam logic [RULE_W-1:0] RULE_STALL_LIMIT    = 3'd6;
	localparam logic [RULE_W-1:0] RULE_ERR_RESP       = 3'd7;

	// htrans encodings.
	localparam logic [1:0] HTRANS_IDLE   = 2'd0;
	localparam logic [1:0] HTRANS_BUSY   = 2'd1;
	localparam logic [1:0] HTRANS_NONSEQ = 2'd2;
	localparam logic [1:0] HTRANS_SEQ    = 2'd3;

	localparam logic [2:0] HSIZE_WORD = 3'd2; // widest legal hsize.

	// limits and derived widths.
	localparam int MAX_BUS_STALL = 8;
	localparam int STALL_W       = $clog2(MAX_BUS_STALL + 2);
	localparam int FIFO_DEPTH    = 4;
	localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W    = $clog2(FIFO_DEPTH + 1);
	localparam int REC_W         = RULE_W + ADDR_W;
	localparam int DROP_W        = 8;

	// ==================================================
	// APB register offsets.
	// ==================================================
	localparam logic [APB_ADDR_W-1:0] REG_STATUS = 8'h00;
	localparam logic [APB_ADDR_W-1:0] REG_I_RULE = 8'h04;
	localparam logic [APB_ADDR_W-1:0] REG_I_ADDR = 8'h08;
	localparam logic [APB_ADDR_W-1:0] REG_I_POP  = 8'h0C;
	localparam logic [APB_ADDR_W-1:0] REG_D_RULE = 8'h10;
	localparam logic [APB_ADDR_W-1:0] REG_D_ADDR = 8'h14;
	localparam logic [APB_ADDR_W-1:0] REG_D_POP  = 8'h18;
	localparam logic [APB_ADDR_W-1:0] REG_DROPS  = 8'h1C;

endpackage

`default_nettype wire
